// ==== common/link_pkg.sv ====
package link_pkg;

  // line and payload widths
  localparam int SYM_W  = 10;
  localparam int DATA_W = 8;

  // wide enough for any bit offset inside one symbol
  localparam int OFF_W = $clog2(SYM_W);

  typedef logic [SYM_W-1:0]  sym_t;
  typedef logic [DATA_W-1:0] byte_t;

  // user defined commas, sent alternately
  localparam sym_t COMMA_P = 10'h283;
  localparam sym_t COMMA_N = 10'h17C;

  // data symbol is {0, byte, 1}
  // bit 9 set rules out COMMA_P, bit 0 clear rules out COMMA_N
  function automatic sym_t make_data_sym(input byte_t b);
    return {1'b0, b, 1'b1};
  endfunction

  function automatic logic is_comma(input sym_t s);
    return (s == COMMA_P) || (s == COMMA_N);
  endfunction

  function automatic logic is_data_sym(input sym_t s);
    return !s[SYM_W-1] && s[0];
  endfunction

  // payload field of a data symbol
  function automatic byte_t sym_byte(input sym_t s);
    return s[DATA_W:1];
  endfunction

endpackage

// ==== tx/tx_framer.sv ====
`timescale 1ns/1ps

module tx_framer import link_pkg::*; #(
  parameter int COMMA_PERIOD = 16
) (
  input  logic  tx_pclk,
  input  logic  rst_n,
  input  logic  in_req,
  output logic  in_ack,
  input  byte_t in_data,
  output sym_t  tx_sym
);

  localparam int SLOT_W = (COMMA_PERIOD > 1) ? $clog2(COMMA_PERIOD) : 1;

  logic [SLOT_W-1:0] slot_cnt;
  logic              hold_full;
  byte_t             hold_byte;
  logic              comma_pol;  // 0 sends COMMA_P next
  logic              take_byte;
  logic              send_data;

  // new request, not yet acked, room in the holding register
  assign take_byte = in_req && !in_ack && !hold_full;

  // slot 0 always carries a comma
  assign send_data = hold_full && (slot_cnt != '0);

  // input handshake and holding register state
  always_ff @(posedge tx_pclk or negedge rst_n) begin
    if (!rst_n) begin
      in_ack    <= 1'b0;
      hold_full <= 1'b0;
    end else begin
      if (take_byte) begin
        in_ack    <= 1'b1;
        hold_full <= 1'b1;
      end else begin
        if (in_ack && !in_req) begin
          in_ack <= 1'b0;  // source released req
        end
        if (send_data) begin
          hold_full <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge tx_pclk) begin
    if (take_byte) begin
      hold_byte <= in_data;
    end
  end

  // slot counter, comma polarity and line symbol
  always_ff @(posedge tx_pclk or negedge rst_n) begin
    if (!rst_n) begin
      slot_cnt  <= '0;
      comma_pol <= 1'b0;
      tx_sym    <= '0;
    end else begin
      if (slot_cnt == SLOT_W'(COMMA_PERIOD - 1)) begin
        slot_cnt <= '0;
      end else begin
        slot_cnt <= slot_cnt + 1'b1;
      end

      if (send_data) begin
        tx_sym <= make_data_sym(hold_byte);
      end else begin
        // forced or filler comma
        tx_sym    <= comma_pol ? COMMA_N : COMMA_P;
        comma_pol <= ~comma_pol;
      end
    end
  end

  // source must hold its byte until it sees the ack
  a_in_data_stable: assert property (
    @(posedge tx_pclk) disable iff (!rst_n)
    (in_req && !in_ack) |=> $stable(in_data)
  ) else $error("in_data changed while in_req was waiting for in_ack");

endmodule

// ==== rtl/lane_channel.sv ====
`timescale 1ns/1ps

module lane_channel import link_pkg::*; (
  input  logic       tx_pclk,
  input  logic       rst_n,
  input  logic [3:0] slip,
  input  sym_t       tx_sym,
  output sym_t       line_sym
);

  sym_t               prev_sym;
  logic [2*SYM_W-1:0] pair;

  // serial order is msb first, prev symbol goes out before the current one
  assign pair = {prev_sym, tx_sym};

  // a deserializer that started slip bits early sees the tail of the
  // previous symbol followed by the head of the current one
  always_ff @(posedge tx_pclk or negedge rst_n) begin
    if (!rst_n) begin
      prev_sym <= '0;
      line_sym <= '0;
    end else begin
      prev_sym <= tx_sym;
      line_sym <= sym_t'(pair >> slip);
    end
  end

  a_slip_range: assert property (
    @(posedge tx_pclk) disable iff (!rst_n)
    slip < 4'(SYM_W)
  ) else $error("slip %0d is outside the symbol", slip);

endmodule

// ==== rx/word_aligner.sv ====
`timescale 1ns/1ps

module word_aligner import link_pkg::*; #(
  parameter int LOCK_COUNT = 3
) (
  input  logic             tx_pclk,
  input  logic             rst_n,
  input  sym_t             line_sym,
  output sym_t             rx_sym,
  output logic             rx_valid,
  output logic             locked,
  output logic [OFF_W-1:0] align_offset
);

  localparam int RUN_W        = $clog2(LOCK_COUNT + 1);
  localparam int RELOCK_COUNT = 2;
  localparam int OTH_W        = $clog2(RELOCK_COUNT + 1);

  sym_t               prev_sym;
  logic [2*SYM_W-1:0] hist;
  sym_t               win [SYM_W];
  logic [SYM_W-1:0]   hit;
  logic [OFF_W-1:0]   cand_off;
  logic               cand_hit;
  logic               other_hit;
  logic [OFF_W-1:0]   other_k;
  logic [OFF_W-1:0]   other_off;
  logic [OTH_W-1:0]   other_cnt;
  logic [RUN_W-1:0]   run_cnt;
  logic               relock;

  assign hist = {prev_sym, line_sym};

  // window k undoes a channel slip of k
  for (genvar k = 0; k < SYM_W; k++) begin : g_win
    assign win[k] = hist[(SYM_W - k) +: SYM_W];
    assign hit[k] = is_comma(win[k]);
  end

  assign cand_hit = hit[cand_off];

  // lowest offset other than the candidate that shows a comma
  always_comb begin
    other_hit = 1'b0;
    other_k   = '0;
    for (int k = SYM_W - 1; k >= 0; k--) begin
      if (hit[k] && (OFF_W'(k) != cand_off)) begin
        other_hit = 1'b1;
        other_k   = OFF_W'(k);
      end
    end
  end

  // second comma in a row at the same foreign offset
  assign relock = locked && other_hit && !cand_hit &&
                  (other_k == other_off) && (other_cnt == OTH_W'(RELOCK_COUNT - 1));

  always_ff @(posedge tx_pclk or negedge rst_n) begin
    if (!rst_n) begin
      prev_sym  <= '0;
      locked    <= 1'b0;
      rx_valid  <= 1'b0;
      cand_off  <= '0;
      run_cnt   <= '0;
      other_off <= '0;
      other_cnt <= '0;
    end else begin
      prev_sym <= line_sym;
      rx_valid <= locked && !relock;
      if (!locked) begin
        other_cnt <= '0;
        if (cand_hit && !other_hit) begin
          run_cnt <= run_cnt + 1'b1;
          if (run_cnt >= RUN_W'(LOCK_COUNT - 1)) begin
            locked <= 1'b1;
          end
        end else if (other_hit && !cand_hit) begin
          cand_off <= other_k;  // restart the run there
          run_cnt  <= RUN_W'(1);
        end else if (other_hit) begin
          run_cnt <= '0;  // commas at two offsets, no evidence
        end
      end else begin
        run_cnt <= '0;
        if (cand_hit) begin
          other_cnt <= '0;
        end else if (relock) begin
          locked    <= 1'b0;
          cand_off  <= other_k;
          run_cnt   <= RUN_W'(1);
          other_cnt <= '0;
        end else if (other_hit) begin
          other_off <= other_k;
          other_cnt <= OTH_W'(1);
        end
      end
    end
  end

  always_ff @(posedge tx_pclk) begin
    rx_sym <= win[cand_off];
  end

  assign align_offset = cand_off;

  a_offset_range: assert property (
    @(posedge tx_pclk) disable iff (!rst_n)
    align_offset < OFF_W'(SYM_W)
  ) else $error("align_offset %0d is outside the symbol", align_offset);

endmodule

// ==== rx/rx_deframer.sv ====
`timescale 1ns/1ps

module rx_deframer import link_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic  tx_pclk,
  input  logic  rst_n,
  input  sym_t  rx_sym,
  input  logic  rx_valid,
  output logic  out_req,
  input  logic  out_ack,
  output byte_t out_data,
  output logic  overflow
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  byte_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             data_in;
  logic             fifo_full;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // commas fail the data format check and are dropped here
  assign data_in   = rx_valid && is_data_sym(rx_sym);
  assign fifo_full = (count == CNT_W'(FIFO_DEPTH));
  assign push      = data_in && !fifo_full;
  // load output reg once the previous handshake has fully closed
  assign pop       = !out_req && !out_ack && (count != '0);

  always_ff @(posedge tx_pclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (data_in && fifo_full) begin
        overflow <= 1'b1;  // sticky
      end
    end
  end

  always_ff @(posedge tx_pclk) begin
    if (push) begin
      mem[wr_ptr] <= sym_byte(rx_sym);
    end
  end

  // output side of the four-phase handshake
  always_ff @(posedge tx_pclk or negedge rst_n) begin
    if (!rst_n) begin
      out_req <= 1'b0;
    end else if (pop) begin
      out_req <= 1'b1;
    end else if (out_req && out_ack) begin
      out_req <= 1'b0;
    end
  end

  always_ff @(posedge tx_pclk) begin
    if (pop) begin
      out_data <= mem[rd_ptr];
    end
  end

  a_req_held: assert property (
    @(posedge tx_pclk) disable iff (!rst_n)
    $fell(out_req) |-> $past(out_ack)
  ) else $error("out_req dropped before out_ack was seen");

endmodule

// ==== rtl/serdes_link_top.sv ====
`timescale 1ns/1ps

module serdes_link_top import link_pkg::*; #(
  parameter int COMMA_PERIOD = 16,
  parameter int LOCK_COUNT   = 3,
  parameter int FIFO_DEPTH   = 8
) (
  input  logic             tx_pclk,
  input  logic             rst_n,
  // byte source
  input  logic             in_req,
  output logic             in_ack,
  input  byte_t            in_data,
  // static channel config
  input  logic [3:0]       slip,
  // byte sink
  output logic             out_req,
  input  logic             out_ack,
  output byte_t            out_data,
  // status
  output logic             locked,
  output logic [OFF_W-1:0] align_offset,
  output logic             overflow
);

  sym_t tx_sym;
  sym_t line_sym;
  sym_t rx_sym;
  logic rx_valid;

  tx_framer #(
    .COMMA_PERIOD(COMMA_PERIOD)
  ) u_tx_framer (
    .tx_pclk (tx_pclk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .in_data (in_data),
    .tx_sym  (tx_sym)
  );

  // stands in for serializer, loopback wire and deserializer
  lane_channel u_lane_channel (
    .tx_pclk  (tx_pclk),
    .rst_n    (rst_n),
    .slip     (slip),
    .tx_sym   (tx_sym),
    .line_sym (line_sym)
  );

  word_aligner #(
    .LOCK_COUNT(LOCK_COUNT)
  ) u_word_aligner (
    .tx_pclk      (tx_pclk),
    .rst_n        (rst_n),
    .line_sym     (line_sym),
    .rx_sym       (rx_sym),
    .rx_valid     (rx_valid),
    .locked       (locked),
    .align_offset (align_offset)
  );

  rx_deframer #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_rx_deframer (
    .tx_pclk  (tx_pclk),
    .rst_n    (rst_n),
    .rx_sym   (rx_sym),
    .rx_valid (rx_valid),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data),
    .overflow (overflow)
  );

endmodule

// ==== test/tb_serdes_link.sv ====
`timescale 1ns/1ps

module tb_serdes_link import link_pkg::*; ();

  localparam int COMMA_PERIOD = 16;
  localparam int LOCK_COUNT   = 3;
  localparam int FIFO_DEPTH   = 8;
  localparam int N_ROWS       = 7;
  localparam int ACK_WAIT     = 4 * COMMA_PERIOD;
  localparam int LOCK_WAIT    = 16 * COMMA_PERIOD;
  localparam int DRAIN_WAIT   = 64 * COMMA_PERIOD;
  localparam int WD_MARGIN    = 2000;

  logic             tx_pclk;
  logic             rst_n;
  logic             in_req;
  logic             in_ack;
  byte_t            in_data;
  logic [3:0]       slip;
  logic             out_req;
  logic             out_ack;
  byte_t            out_data;
  logic             locked;
  logic [OFF_W-1:0] align_offset;
  logic             overflow;

  // one row per slip setting, last row stalls the sink
  int row_slip  [N_ROWS] = '{0, 3, 3, 7, 9, 2, 5};
  int row_count [N_ROWS] = '{12, 10, 8, 16, 10, 12, FIFO_DEPTH + 3};
  bit row_stall [N_ROWS] = '{0, 0, 0, 0, 0, 0, 1};

  byte_t exp_q[$];
  int    errors;
  int    n_checked;
  int    n_discarded;
  bit    discard;     // sink drops bytes left over from a slip change
  bit    sink_stall;

  serdes_link_top #(
    .COMMA_PERIOD(COMMA_PERIOD),
    .LOCK_COUNT  (LOCK_COUNT),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) dut0 (
    .tx_pclk      (tx_pclk),
    .rst_n        (rst_n),
    .in_req       (in_req),
    .in_ack       (in_ack),
    .in_data      (in_data),
    .slip         (slip),
    .out_req      (out_req),
    .out_ack      (out_ack),
    .out_data     (out_data),
    .locked       (locked),
    .align_offset (align_offset),
    .overflow     (overflow)
  );

  always #20 tx_pclk = ~tx_pclk;

  // all drives and samples happen 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge tx_pclk);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  function automatic int watchdog_cycles();
    int total;
    total = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      total += (row_count[r] + 1) * 8 * COMMA_PERIOD;
    end
    return total + WD_MARGIN;
  endfunction

  // one four-phase cycle on the input side
  task automatic send_byte(input byte_t b, input bit expected, output bit ok);
    int n;
    ok      = 1'b0;
    in_data = b;
    in_req  = 1'b1;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!in_ack && n < ACK_WAIT);
    if (!in_ack) begin
      $display("byte 0x%02h was never acked by the framer", b);
      errors++;
      in_req = 1'b0;
      return;
    end
    if (expected) begin
      exp_q.push_back(b);
    end
    in_req = 1'b0;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (in_ack && n < ACK_WAIT);
    if (in_ack) begin
      $display("in_ack stayed high after in_req was dropped");
      errors++;
      return;
    end
    ok = 1'b1;
  endtask

  // a new slip has to knock the old lock out first
  task automatic wait_lock(input bit moved, output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    if (moved) begin
      while (locked && n < LOCK_WAIT) begin
        next_cycle();
        n++;
      end
      if (locked) begin
        $display("lock did not drop within %0d cycles of the slip change", LOCK_WAIT);
        errors++;
        return;
      end
    end
    n = 0;
    while (!locked && n < LOCK_WAIT) begin
      next_cycle();
      n++;
    end
    ok = locked;
    if (!ok) begin
      $display("no lock within %0d cycles", LOCK_WAIT);
      errors++;
    end
  endtask

  task automatic wait_drain(input int r);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_WAIT) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("row %0d: %0d acked bytes were never delivered", r, exp_q.size());
      errors += exp_q.size();
      exp_q.delete();
    end
    wait_cycles(2 * COMMA_PERIOD);  // room for a stray extra byte to show up
  endtask

  task automatic accept_byte(input byte_t got);
    if (discard) begin
      n_discarded++;
    end else if (exp_q.size() == 0) begin
      $display("byte 0x%02h arrived at the sink with nothing outstanding", got);
      errors++;
    end else begin
      check("out_data", exp_q.pop_front(), got);
      n_checked++;
    end
  endtask

  initial begin : sink_proc
    int    delay;
    byte_t got;
    out_ack = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      next_cycle();
      if (out_req) begin
        got = out_data;
        while (sink_stall) begin
          next_cycle();
        end
        delay = $urandom % 7;
        wait_cycles(delay);
        out_ack = 1'b1;
        do begin
          next_cycle();
        end while (out_req);
        out_ack = 1'b0;
        accept_byte(got);
      end
    end
  end

  // sampled on the falling edge, away from the drive point
  initial begin : ack_monitor
    bit prev_ack;
    bit prev_req;
    bit acked;
    prev_ack = 1'b0;
    prev_req = 1'b0;
    acked    = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge tx_pclk);
      if (in_req && !prev_req) begin
        acked = 1'b0;  // new request opens a cycle
      end
      if (in_ack && !prev_ack) begin
        if (acked || !prev_req) begin
          $display("in_ack rose twice or without a request at %0t", $time);
          errors++;
        end
        acked = 1'b1;
      end
      prev_ack = in_ack;
      prev_req = in_req;
    end
  end

  initial begin : watchdog
    int limit;
    limit = watchdog_cycles();
    repeat (limit) @(posedge tx_pclk);
    $display("run timed out after %0d cycles without finishing the rows", limit);
    $display("errors: %0d, bytes checked: %0d", errors, n_checked);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main_proc
    int    n_keep;
    bit    ok;
    bit    moved;
    byte_t b;
    tx_pclk     = 1'b0;
    rst_n       = 1'b0;
    in_req      = 1'b0;
    in_data     = '0;
    slip        = '0;
    errors      = 0;
    n_checked   = 0;
    n_discarded = 0;
    discard     = 1'b0;
    sink_stall  = 1'b0;
    void'($urandom(32'h51a7));

    repeat (10) @(posedge tx_pclk);
    #2;
    rst_n = 1'b1;
    check("in_ack", 0, in_ack);
    check("out_req", 0, out_req);
    check("locked", 0, locked);
    check("overflow", 0, overflow);
    check("align_offset", 0, align_offset);

    for (int r = 0; r < N_ROWS; r++) begin
      discard = 1'b1;
      moved   = (r != 0) && (row_slip[r] != row_slip[r - 1]);
      slip    = 4'(row_slip[r]);
      wait_lock(moved, ok);
      if (!ok) begin
        continue;
      end
      check("align_offset", row_slip[r], align_offset);
      wait_cycles(4 * COMMA_PERIOD);  // flush symbols from the relock window
      discard = 1'b0;

      sink_stall = row_stall[r];
      n_keep     = row_stall[r] ? row_count[r] - 2 : row_count[r];
      for (int i = 0; i < row_count[r]; i++) begin
        if (row_stall[r] && i == n_keep) begin
          wait_cycles(4 * COMMA_PERIOD);
          check("overflow", 0, overflow);
        end
        // no end to end flow control, keep within the receive buffer
        while (!row_stall[r] && exp_q.size() >= FIFO_DEPTH) begin
          next_cycle();
        end
        b = byte_t'($urandom);
        send_byte(b, i < n_keep, ok);
      end
      if (row_stall[r]) begin
        wait_cycles(4 * COMMA_PERIOD);
        check("overflow", 1, overflow);
        sink_stall = 1'b0;
      end
      wait_drain(r);
    end

    $display("errors: %0d, bytes checked: %0d, bytes discarded after slip changes: %0d",
             errors, n_checked, n_discarded);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
common/link_pkg.sv
tx/tx_framer.sv
rtl/lane_channel.sv
rx/word_aligner.sv
rx/rx_deframer.sv
rtl/serdes_link_top.sv
test/tb_serdes_link.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_serdes_link
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
